//--- logic/icache_pkg.sv
package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // address and instruction words
    //////////////////////////////////////////////////////////////////////

    // byte address width, one word
    localparam int ADDR_W = 32;

    // filler for an empty second issue slot
    // encodes andi r0, r0, 0
    localparam logic [31:0] INSN_NOP = 32'h0340_0000;

    //////////////////////////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////////////////////////

    // size code per beat: 0 byte, 1 half, 2 word
    localparam logic [1:0] MEM_SIZE_WORD = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // controller states
    //////////////////////////////////////////////////////////////////////

    // nothing in flight
    localparam logic [2:0] ST_IDLE   = 3'd0;
    // stores read, tag compare this cycle
    localparam logic [2:0] ST_LOOKUP = 3'd1;
    // line request waiting for address accept
    localparam logic [2:0] ST_MISS   = 3'd2;
    // waiting for the line to come back
    localparam logic [2:0] ST_REFILL = 3'd3;
    // response held by the fetch stage
    localparam logic [2:0] ST_HOLD   = 3'd4;

endpackage

//--- logic/icache_tag_store.sv
module icache_tag_store #(
    parameter int  INDEX_W  = 4,
    parameter int  OFFSET_W = 2,
    localparam int TAG_W    = icache_pkg::ADDR_W - INDEX_W - OFFSET_W - 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] rd_index,
    input  logic [TAG_W-1:0]   cmp_tag,
    output logic [1:0]         hit,
    output logic               victim,
    input  logic [1:0]         tag_we,
    input  logic [INDEX_W-1:0] refill_index,
    input  logic [TAG_W-1:0]   refill_tag,
    input  logic               lru_touch,
    input  logic               lru_way,
    input  logic               inval
);

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]         tag_mem [2][SETS];
    logic [1:0][SETS-1:0]     valid_mem;
    // per set, the way used least recently
    logic [SETS-1:0]          lru_bits;
    logic [TAG_W-1:0]         rd_tag [2];
    logic [1:0]               rd_valid;

    // tag arrays, one-cycle read
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][refill_index] <= refill_tag;
            end
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_mem <= '0;
            lru_bits  <= '0;
            rd_valid  <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (tag_we[w]) begin
                    valid_mem[w][refill_index] <= 1'b1;
                end
                rd_valid[w] <= valid_mem[w][rd_index];
            end
            // cache op clears the whole set
            if (inval) begin
                valid_mem[0][refill_index] <= 1'b0;
                valid_mem[1][refill_index] <= 1'b0;
                lru_bits[refill_index]     <= 1'b0;
            end else if (lru_touch) begin
                lru_bits[refill_index] <= ~lru_way;
            end
        end
    end

    assign hit[0] = rd_valid[0] && (rd_tag[0] == cmp_tag);
    assign hit[1] = rd_valid[1] && (rd_tag[1] == cmp_tag);

    // empty way first, then lru
    always_comb begin
        if (!rd_valid[0]) begin
            victim = 1'b0;
        end else if (!rd_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_bits[refill_index];
        end
    end

endmodule

//--- logic/icache_data_store.sv
module icache_data_store #(
    parameter int  INDEX_W  = 4,
    parameter int  OFFSET_W = 2,
    localparam int LINE_W   = 32 << OFFSET_W
) (
    input  logic               clk,
    input  logic [INDEX_W-1:0] rd_index,
    output logic [LINE_W-1:0]  line0,
    output logic [LINE_W-1:0]  line1,
    input  logic [1:0]         data_we,
    input  logic [INDEX_W-1:0] refill_index,
    input  logic [LINE_W-1:0]  mem_line
);

    localparam int SETS = 1 << INDEX_W;

    logic [LINE_W-1:0] line_mem [2][SETS];
    logic [LINE_W-1:0] rd_line [2];

    //////////////////////////////////////////////////////////////////////
    // line arrays
    //////////////////////////////////////////////////////////////////////

    // whole line written at once from the burst
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (data_we[w]) begin
                line_mem[w][refill_index] <= mem_line;
            end
        end
    end

    // both ways read every cycle
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            rd_line[w] <= line_mem[w][rd_index];
        end
    end

    assign line0 = rd_line[0];
    assign line1 = rd_line[1];

endmodule

//--- logic/icache_ctrl.sv
module icache_ctrl #(
    parameter int  INDEX_W  = 4,
    parameter int  OFFSET_W = 2,
    localparam int TAG_W    = icache_pkg::ADDR_W - INDEX_W - OFFSET_W - 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr,
    input  logic                          req_inval,
    input  logic                          req_hold,
    output logic                          req_ready,
    output logic                          resp_valid,
    output logic [icache_pkg::ADDR_W-1:0] resp_pc,
    output logic                          mem_req,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr,
    output logic [1:0]                    mem_size,
    input  logic                          mem_addr_ok,
    input  logic                          mem_data_ok,
    output logic [INDEX_W-1:0]            rd_index,
    input  logic [1:0]                    hit,
    input  logic                          victim,
    output logic [1:0]                    tag_we,
    output logic [1:0]                    data_we,
    output logic [INDEX_W-1:0]            refill_index,
    output logic [TAG_W-1:0]              refill_tag,
    output logic                          lru_touch,
    output logic                          lru_way,
    output logic                          inval,
    output logic                          sel_way,
    output logic                          sel_return,
    output logic [OFFSET_W-1:0]           sel_word,
    output logic                          load_hold,
    output logic                          send_nop
);
    import icache_pkg::*;

    localparam int IDX_LO = OFFSET_W + 2;
    localparam int TAG_LO = IDX_LO + INDEX_W;

    logic [2:0]        state;
    logic [2:0]        state_nxt;
    logic [ADDR_W-1:0] buf_addr;
    logic              buf_inval;
    logic              accept;
    logic              lookup_hit;
    logic              refill_done;

    //////////////////////////////////////////////////////////////////////
    // request buffer
    //////////////////////////////////////////////////////////////////////

    assign accept = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr <= req_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_inval <= 1'b0;
        end else if (accept) begin
            buf_inval <= req_inval;
        end
    end

    // new index on accept, else keep rereading the buffered set
    assign rd_index = accept ? req_addr[TAG_LO-1:IDX_LO] : buf_addr[TAG_LO-1:IDX_LO];

    assign refill_index = buf_addr[TAG_LO-1:IDX_LO];
    assign refill_tag   = buf_addr[ADDR_W-1:TAG_LO];
    assign sel_word     = buf_addr[IDX_LO-1:2];
    assign resp_pc      = buf_addr;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    assign lookup_hit  = (state == ST_LOOKUP) && !buf_inval && (|hit);
    assign refill_done = (state == ST_REFILL) && mem_data_ok;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (buf_inval) begin
                    state_nxt = ST_IDLE;
                end else if (!(|hit)) begin
                    state_nxt = ST_MISS;
                end else if (req_hold) begin
                    state_nxt = ST_HOLD;
                end else if (!accept) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_MISS: begin
                if (mem_addr_ok) begin
                    state_nxt = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem_data_ok) begin
                    state_nxt = req_hold ? ST_HOLD : ST_IDLE;
                end
            end
            ST_HOLD: begin
                if (!req_hold) begin
                    state_nxt = accept ? ST_LOOKUP : ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // no accept while a set is being written
    always_comb begin
        case (state)
            ST_IDLE:   req_ready = 1'b1;
            ST_LOOKUP: req_ready = lookup_hit && !req_hold;
            ST_HOLD:   req_ready = !req_hold;
            default:   req_ready = 1'b0;
        endcase
    end

    assign resp_valid = lookup_hit || refill_done || (state == ST_HOLD);
    assign load_hold  = resp_valid && req_hold;
    assign send_nop   = !resp_valid;
    assign sel_way    = hit[1];
    assign sel_return = (state == ST_REFILL);

    // memory side
    assign mem_req  = (state == ST_MISS);
    assign mem_addr = {buf_addr[ADDR_W-1:IDX_LO], {IDX_LO{1'b0}}};
    assign mem_size = MEM_SIZE_WORD;

    // refill goes to the victim way
    assign tag_we    = refill_done ? (victim ? 2'b10 : 2'b01) : 2'b00;
    assign data_we   = tag_we;
    assign lru_touch = lookup_hit || refill_done;
    assign lru_way   = refill_done ? victim : hit[1];
    assign inval     = (state == ST_LOOKUP) && buf_inval;

    // request stays up until the address is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_addr_ok |=> mem_req);

    // a line is never cached in both ways
    assert property (@(posedge clk) disable iff (!rst_n)
        state == ST_LOOKUP |-> !(&hit));

endmodule

//--- logic/icache_fetch_align.sv
module icache_fetch_align #(
    parameter int  OFFSET_W = 2,
    localparam int LINE_W   = 32 << OFFSET_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [LINE_W-1:0]   line0,
    input  logic [LINE_W-1:0]   line1,
    input  logic [LINE_W-1:0]   mem_line,
    input  logic                sel_way,
    input  logic                sel_return,
    input  logic [OFFSET_W-1:0] sel_word,
    input  logic                load_hold,
    input  logic                send_nop,
    output logic [63:0]         resp_insn,
    output logic                resp_pair
);
    import icache_pkg::*;

    logic [LINE_W-1:0]   src_line;
    logic [OFFSET_W-1:0] upper_word;
    logic [63:0]         live_insn;
    logic                live_pair;
    logic [63:0]         held_insn;
    logic                held_pair;
    logic                replay;

    // returned line bypasses the arrays
    assign src_line = sel_return ? mem_line : (sel_way ? line1 : line0);

    assign upper_word = sel_word | OFFSET_W'(1);

    // second slot only from an even offset
    always_comb begin
        live_insn[31:0] = src_line[sel_word*32 +: 32];
        if (sel_word[0]) begin
            live_insn[63:32] = INSN_NOP;
            live_pair        = 1'b0;
        end else begin
            live_insn[63:32] = src_line[upper_word*32 +: 32];
            live_pair        = 1'b1;
        end
    end

    always_comb begin
        if (send_nop) begin
            resp_insn = {INSN_NOP, INSN_NOP};
            resp_pair = 1'b0;
        end else if (replay) begin
            resp_insn = held_insn;
            resp_pair = held_pair;
        end else begin
            resp_insn = live_insn;
            resp_pair = live_pair;
        end
    end

    // captures what is on the outputs, so a held pair recirculates
    always_ff @(posedge clk) begin
        if (load_hold) begin
            held_insn <= resp_insn;
            held_pair <= resp_pair;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            replay <= 1'b0;
        end else begin
            replay <= load_hold;
        end
    end

endmodule

//--- logic/icache_top.sv
module icache_top #(
    parameter int  INDEX_W  = 4,
    parameter int  OFFSET_W = 2,
    localparam int LINE_W   = 32 << OFFSET_W
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic [icache_pkg::ADDR_W-1:0] req_addr,
    input  logic                          req_inval,
    input  logic                          req_hold,
    output logic                          req_ready,
    output logic                          resp_valid,
    output logic [icache_pkg::ADDR_W-1:0] resp_pc,
    output logic [63:0]                   resp_insn,
    output logic                          resp_pair,
    output logic                          mem_req,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr,
    output logic [1:0]                    mem_size,
    input  logic                          mem_addr_ok,
    input  logic                          mem_data_ok,
    input  logic [LINE_W-1:0]             mem_line
);
    import icache_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - 2;

    logic [INDEX_W-1:0]  rd_index;
    logic [1:0]          hit;
    logic                victim;
    logic [1:0]          tag_we;
    logic [1:0]          data_we;
    logic [INDEX_W-1:0]  refill_index;
    logic [TAG_W-1:0]    refill_tag;
    logic                lru_touch;
    logic                lru_way;
    logic                inval;
    logic                sel_way;
    logic                sel_return;
    logic [OFFSET_W-1:0] sel_word;
    logic                load_hold;
    logic                send_nop;
    logic [LINE_W-1:0]   line0;
    logic [LINE_W-1:0]   line1;

    icache_ctrl #(
        .INDEX_W  (INDEX_W),
        .OFFSET_W (OFFSET_W)
    ) icache_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_inval    (req_inval),
        .req_hold     (req_hold),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp_pc      (resp_pc),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_size     (mem_size),
        .mem_addr_ok  (mem_addr_ok),
        .mem_data_ok  (mem_data_ok),
        .rd_index     (rd_index),
        .hit          (hit),
        .victim       (victim),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .refill_index (refill_index),
        .refill_tag   (refill_tag),
        .lru_touch    (lru_touch),
        .lru_way      (lru_way),
        .inval        (inval),
        .sel_way      (sel_way),
        .sel_return   (sel_return),
        .sel_word     (sel_word),
        .load_hold    (load_hold),
        .send_nop     (send_nop)
    );

    // compare tag is the buffered request tag
    icache_tag_store #(
        .INDEX_W  (INDEX_W),
        .OFFSET_W (OFFSET_W)
    ) icache_tag_store_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_index     (rd_index),
        .cmp_tag      (refill_tag),
        .hit          (hit),
        .victim       (victim),
        .tag_we       (tag_we),
        .refill_index (refill_index),
        .refill_tag   (refill_tag),
        .lru_touch    (lru_touch),
        .lru_way      (lru_way),
        .inval        (inval)
    );

    icache_data_store #(
        .INDEX_W  (INDEX_W),
        .OFFSET_W (OFFSET_W)
    ) icache_data_store_i (
        .clk          (clk),
        .rd_index     (rd_index),
        .line0        (line0),
        .line1        (line1),
        .data_we      (data_we),
        .refill_index (refill_index),
        .mem_line     (mem_line)
    );

    icache_fetch_align #(
        .OFFSET_W (OFFSET_W)
    ) icache_fetch_align_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .line0      (line0),
        .line1      (line1),
        .mem_line   (mem_line),
        .sel_way    (sel_way),
        .sel_return (sel_return),
        .sel_word   (sel_word),
        .load_hold  (load_hold),
        .send_nop   (send_nop),
        .resp_insn  (resp_insn),
        .resp_pair  (resp_pair)
    );

endmodule

//--- dv/icache_tb.sv
module icache_tb;
    import icache_pkg::*;

    localparam int INDEX_W      = 4;
    localparam int OFFSET_W     = 2;
    localparam int LINE_W       = 32 << OFFSET_W;
    localparam int LINE_BYTES   = 4 << OFFSET_W;
    localparam int SETS         = 1 << INDEX_W;
    localparam int TAG_W        = ADDR_W - INDEX_W - OFFSET_W - 2;
    localparam int PERIOD       = 10;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_DELAY    = 6;
    localparam int MAX_HOLD     = 8;
    localparam int RESP_LIMIT   = 2 * MAX_DELAY + 8;
    localparam int OP_CYCLES    = 2 * MAX_DELAY + MAX_HOLD + 10;
    localparam int MAX_OPS      = 64;

    // backing memory word pattern
    localparam logic [31:0] WORD_KEY = 32'h5a3c_9e17;

    localparam logic [31:0] OP_END   = 32'd0;
    localparam logic [31:0] OP_FETCH = 32'd1;
    localparam logic [31:0] OP_INVAL = 32'd2;
    localparam logic [31:0] OP_HOLD  = 32'd3;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    logic [31:0]       req_addr;
    logic              req_inval;
    logic              req_hold;
    logic              req_ready;
    logic              resp_valid;
    logic [31:0]       resp_pc;
    logic [63:0]       resp_insn;
    logic              resp_pair;
    logic              mem_req;
    logic [31:0]       mem_addr;
    logic [1:0]        mem_size;
    logic              mem_addr_ok;
    logic              mem_data_ok;
    logic [LINE_W-1:0] mem_line;

    logic [31:0]       op_mem [4*MAX_OPS];
    int                n_ops;
    int                errors;
    int unsigned       rng_state = 57;

    // reference cache state
    logic [TAG_W-1:0]  model_tag [2][SETS];
    logic              model_valid [2][SETS];
    logic              model_lru [SETS];

    icache_top #(
        .INDEX_W  (INDEX_W),
        .OFFSET_W (OFFSET_W)
    ) icache_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_inval   (req_inval),
        .req_hold    (req_hold),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_pc     (resp_pc),
        .resp_insn   (resp_insn),
        .resp_pair   (resp_pair),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_size    (mem_size),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] word_at(logic [31:0] byte_addr);
        return byte_addr ^ WORD_KEY;
    endfunction

    function automatic logic [LINE_W-1:0] burst_line(logic [31:0] base);
        logic [LINE_W-1:0] line;
        for (int w = 0; w < (1 << OFFSET_W); w++) begin
            line[w*32 +: 32] = word_at(base + 32'(w * 4));
        end
        return line;
    endfunction

    // addressed word low, next word high, nop from an odd offset
    function automatic logic [63:0] expected_insn(logic [31:0] addr);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = word_at({addr[31:2], 2'b00});
        if (addr[2]) begin
            hi = INSN_NOP;
        end else begin
            hi = word_at({addr[31:2], 2'b00} + 32'd4);
        end
        return {hi, lo};
    endfunction

    function automatic int random_delay();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'((rng_state >> 16) % (MAX_DELAY + 1));
    endfunction

    // returns 1 on a predicted hit and updates tags and lru
    function automatic bit predict_fetch(logic [31:0] addr);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        int                 way;
        idx = addr[OFFSET_W+2 +: INDEX_W];
        tag = addr[ADDR_W-1 -: TAG_W];
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][idx] && model_tag[w][idx] == tag) begin
                way = w;
            end
        end
        if (way >= 0) begin
            model_lru[idx] = (way == 0);
            return 1'b1;
        end
        // empty way first, else least recently used
        if (!model_valid[0][idx]) begin
            way = 0;
        end else if (!model_valid[1][idx]) begin
            way = 1;
        end else begin
            way = model_lru[idx] ? 1 : 0;
        end
        model_valid[way][idx] = 1'b1;
        model_tag[way][idx]   = tag;
        model_lru[idx]        = (way == 0);
        return 1'b0;
    endfunction

    function automatic void clear_set(logic [31:0] addr);
        logic [INDEX_W-1:0] idx;
        idx = addr[OFFSET_W+2 +: INDEX_W];
        model_valid[0][idx] = 1'b0;
        model_valid[1][idx] = 1'b0;
        model_lru[idx]      = 1'b0;
    endfunction

    task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(bit cond, string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory model, random delays on both strobes
    //////////////////////////////////////////////////////////////////////

    initial begin : memory_model
        logic [31:0] base;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_line    = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                base = mem_addr;
                repeat (random_delay()) @(negedge clk);
                mem_addr_ok = 1'b1;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                repeat (random_delay()) @(negedge clk);
                mem_line    = burst_line(base);
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // operations
    //////////////////////////////////////////////////////////////////////

    task automatic fetch_and_check(logic [31:0] addr, int hold_len, bit want_hit);
        bit          exp_hit;
        bit          saw_req;
        int          cycles;
        logic [63:0] exp_insn;
        exp_hit  = predict_fetch(addr);
        exp_insn = expected_insn(addr);
        expect_true(exp_hit == want_hit, "input file and reference model disagree on hit or miss");
        saw_req = 1'b0;
        cycles  = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = addr;
        req_inval = 1'b0;
        req_hold  = (hold_len > 0);
        #1;
        while (!req_ready && cycles < RESP_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        expect_true(req_ready, "fetch request was never accepted");
        // accepted at the rising edge just passed
        @(negedge clk);
        req_valid = 1'b0;
        #1;
        cycles = 1;
        while (!resp_valid && cycles < RESP_LIMIT) begin
            if (mem_req && !saw_req) begin
                saw_req = 1'b1;
                compare_value("mem_addr", 64'(mem_addr), 64'(addr & ~32'(LINE_BYTES - 1)));
                compare_value("mem_size", 64'(mem_size), 64'(MEM_SIZE_WORD));
            end
            @(negedge clk);
            #1;
            cycles++;
        end
        expect_true(resp_valid, "no response within the response time limit");
        if (exp_hit) begin
            expect_true(!saw_req, "memory request on a fetch that should hit");
            expect_true(cycles == 1, "hit response did not come one cycle after acceptance");
        end else begin
            expect_true(saw_req, "no memory request on a fetch that should miss");
        end
        compare_value("resp_pc", 64'(resp_pc), 64'(addr));
        compare_value("resp_insn", resp_insn, exp_insn);
        compare_value("resp_pair", 64'(resp_pair), 64'(!addr[2]));
        if (hold_len > 0) begin
            expect_true(!req_ready, "req_ready high while the response is held");
            repeat (hold_len) begin
                @(negedge clk);
                #1;
                expect_true(resp_valid, "resp_valid dropped while the response is held");
                expect_true(!req_ready, "req_ready high while the response is held");
                compare_value("resp_pc", 64'(resp_pc), 64'(addr));
                compare_value("resp_insn", resp_insn, exp_insn);
                compare_value("resp_pair", 64'(resp_pair), 64'(!addr[2]));
            end
            @(negedge clk);
            req_hold = 1'b0;
            #1;
            expect_true(resp_valid && req_ready, "held response not released when hold dropped");
            compare_value("resp_insn", resp_insn, exp_insn);
        end
        if (exp_hit) begin
            // a hit starts no line fetch after its response
            @(negedge clk);
            #1;
            expect_true(!mem_req, "memory request after a fetch that should hit");
        end
    endtask

    task automatic invalidate_set(logic [31:0] addr);
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = addr;
        req_inval = 1'b1;
        req_hold  = 1'b0;
        #1;
        expect_true(req_ready, "cache not ready for the invalidate");
        @(negedge clk);
        req_valid = 1'b0;
        req_inval = 1'b0;
        #1;
        expect_true(!resp_valid && !mem_req, "invalidate produced a response or a memory request");
        @(negedge clk);
        #1;
        expect_true(req_ready && !resp_valid, "cache still busy one cycle after an invalidate");
        clear_set(addr);
    endtask

    initial begin : stimulus
        int          errs_before;
        int          passed;
        int          failed;
        logic [31:0] op;
        logic [31:0] addr;
        string       kind;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_inval = 1'b0;
        req_hold  = 1'b0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        for (int i = 0; i < 4 * MAX_OPS; i++) begin
            op_mem[i] = '0;
        end
        $readmemh("dv/icache_input.txt", op_mem);
        n_ops = 0;
        while (n_ops < MAX_OPS && op_mem[4*n_ops] != OP_END) begin
            n_ops++;
        end
        for (int s = 0; s < SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s]      = 1'b0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        expect_true(req_ready && !resp_valid && !mem_req, "wrong handshake levels after reset");
        if (errors == 0) begin
            passed++;
            $display("test 0 reset passed");
        end else begin
            failed++;
            $display("test 0 reset failed");
        end

        for (int i = 0; i < n_ops; i++) begin
            errs_before = errors;
            op          = op_mem[4*i];
            addr        = op_mem[4*i+1];
            case (op)
                OP_FETCH: begin
                    kind = "fetch";
                    fetch_and_check(addr, 0, op_mem[4*i+3][0]);
                end
                OP_HOLD: begin
                    kind = "hold";
                    fetch_and_check(addr, int'(op_mem[4*i+2]), op_mem[4*i+3][0]);
                end
                OP_INVAL: begin
                    kind = "invalidate";
                    invalidate_set(addr);
                end
                default: begin
                    kind = "unknown";
                    expect_true(1'b0, "unknown operation code in the input file");
                end
            endcase
            if (errors == errs_before) begin
                passed++;
                $display("test %0d %s %h passed", i + 1, kind, addr);
            end else begin
                failed++;
                $display("test %0d %s %h failed", i + 1, kind, addr);
            end
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // run length follows the number of operations read
    initial begin : watchdog
        int limit;
        #1;
        limit = (n_ops * OP_CYCLES + RESET_CYCLES + 20) * PERIOD;
        #(limit);
        $display("run did not finish within %0d time units", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- dv/icache_input.txt
// columns, all hex: op addr hold hit
// op 1 fetch, 2 invalidate, 3 fetch with the response held for hold cycles, 0 ends the list
// hit is 1 where the fetch is expected to hit the cache
1 00000104 0 0
1 00000100 0 1
1 00000108 0 1
1 0000010c 0 1
1 00000110 0 0
1 00000114 0 1
// three tags in set 3
1 00000030 0 0
1 00000134 0 0
1 00000038 0 1
1 00000230 0 0
1 0000003c 0 1
1 00000130 0 0
1 00000234 0 0
1 00000138 0 1
1 00000030 0 0
// held responses on hit and miss
3 00000108 4 1
1 00000100 0 1
3 00000540 3 0
1 00000544 0 1
// invalidate then refetch
2 00000134 0 0
1 00000138 0 0
1 00000230 0 0
1 00000130 0 1
2 00000100 0 0
1 0000010c 0 0
1 00000104 0 1
1 00008104 0 0
3 0000810c 2 1
0 00000000 0 0

//--- list.f
logic/icache_pkg.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_ctrl.sv
logic/icache_fetch_align.sv
logic/icache_top.sv
dv/icache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module icache_tb -f list.f -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
